// File: build.f
+incdir+verification
rtl/fifo_pkg.sv
rtl/ptr_sync.sv
rtl/wr_ptr_ctrl.sv
rtl/rd_ptr_ctrl.sv
rtl/fifo_mem.sv
rtl/async_fifo.sv
verification/tb_async_fifo.sv

// File: rtl/async_fifo.sv
/* Dual-clock FIFO top, joins the pointer sides, both pointer
   synchronizers and the two-port RAM */

`timescale 1ns/1ns

module async_fifo #(
    parameter int ADDR_W       = fifo_pkg::DEF_ADDR_W,
    parameter int DATA_W       = fifo_pkg::DEF_DATA_W,
    parameter int AFULL_LEVEL  = (2 ** ADDR_W) - 1,
    parameter int AEMPTY_LEVEL = 10
) (
    input  logic                rstn_i,
    input  logic                wclk_i,
    input  logic                rclk_i,
    input  logic                wen_i,
    input  logic [DATA_W-1:0]   wdata_i,
    input  logic                ren_i,
    output logic [DATA_W-1:0]   rdata_o,
    output fifo_pkg::wr_flags_t wr_flags_o,
    output fifo_pkg::rd_flags_t rd_flags_o,
    output logic [ADDR_W:0]     wcount_o,
    output logic [ADDR_W:0]     rcount_o
);

    // Gray pointers leaving their own domain
    logic [ADDR_W:0]   wr_gray;
    logic [ADDR_W:0]   rd_gray;
    // Binary pointers after the crossing
    logic [ADDR_W:0]   wr_bin_sync;
    logic [ADDR_W:0]   rd_bin_sync;
    // RAM control
    logic              mem_we;
    logic [ADDR_W-1:0] mem_waddr;
    logic [ADDR_W-1:0] mem_raddr;

    // --------------------
    // Write clock domain
    // --------------------

    wr_ptr_ctrl #(
        .ADDR_W      (ADDR_W),
        .AFULL_LEVEL (AFULL_LEVEL)
    ) u_wr_ptr_ctrl (
        .wclk_i        (wclk_i),
        .rstn_i        (rstn_i),
        .wen_i         (wen_i),
        .rd_bin_sync_i (rd_bin_sync),
        .wr_gray_o     (wr_gray),
        .mem_we_o      (mem_we),
        .mem_waddr_o   (mem_waddr),
        .wr_flags_o    (wr_flags_o),
        .wcount_o      (wcount_o)
    );

    // Read pointer into the write domain
    ptr_sync #(
        .PTR_W (ADDR_W + 1)
    ) rd_to_wr_sync (
        .dclk_i     (wclk_i),
        .rstn_i     (rstn_i),
        .gray_ptr_i (rd_gray),
        .bin_ptr_o  (rd_bin_sync)
    );

    // --------------------
    // Read clock domain
    // --------------------

    rd_ptr_ctrl #(
        .ADDR_W       (ADDR_W),
        .AEMPTY_LEVEL (AEMPTY_LEVEL)
    ) u_rd_ptr_ctrl (
        .rclk_i        (rclk_i),
        .rstn_i        (rstn_i),
        .ren_i         (ren_i),
        .wr_bin_sync_i (wr_bin_sync),
        .rd_gray_o     (rd_gray),
        .mem_raddr_o   (mem_raddr),
        .rd_flags_o    (rd_flags_o),
        .rcount_o      (rcount_o)
    );

    // Write pointer into the read domain
    ptr_sync #(
        .PTR_W (ADDR_W + 1)
    ) wr_to_rd_sync (
        .dclk_i     (rclk_i),
        .rstn_i     (rstn_i),
        .gray_ptr_i (wr_gray),
        .bin_ptr_o  (wr_bin_sync)
    );

    // Storage, written on wclk and read on rclk
    fifo_mem #(
        .ADDR_W (ADDR_W),
        .DATA_W (DATA_W)
    ) u_fifo_mem (
        .wclk_i  (wclk_i),
        .rclk_i  (rclk_i),
        .we_i    (mem_we),
        .waddr_i (mem_waddr),
        .wdata_i (wdata_i),
        .raddr_i (mem_raddr),
        .rdata_o (rdata_o)
    );

endmodule

// File: rtl/fifo_mem.sv
/* Two-port RAM, write on wclk, read address registered on rclk */

`timescale 1ns/1ns

module fifo_mem #(
    parameter int ADDR_W = fifo_pkg::DEF_ADDR_W,
    parameter int DATA_W = fifo_pkg::DEF_DATA_W
) (
    input  logic              wclk_i,
    input  logic              rclk_i,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] waddr_i,
    input  logic [DATA_W-1:0] wdata_i,
    input  logic [ADDR_W-1:0] raddr_i,
    output logic [DATA_W-1:0] rdata_o
);

    // Storage array
    logic [DATA_W-1:0] ram_q [2 ** ADDR_W];
    logic [ADDR_W-1:0] raddr_q;

    // Write port, one wclk edge of latency
    always_ff @(posedge wclk_i) begin
        if (we_i) begin
            ram_q[waddr_i] <= wdata_i;
        end
    end

    // Read address register
    always_ff @(posedge rclk_i) begin
        raddr_q <= raddr_i;
    end

    // Data follows the address from the previous rclk edge
    assign rdata_o = ram_q[raddr_q];

endmodule

// File: rtl/fifo_pkg.sv
/* Shared widths, flag structs and Gray code conversion functions
   for the dual-clock FIFO */

package fifo_pkg;

    // --------------------
    // Default widths
    // --------------------

    // Address width, depth is 2**DEF_ADDR_W
    localparam int DEF_ADDR_W = 5;
    // Payload width of one word
    localparam int DEF_DATA_W = 32;
    // Widest pointer the conversion functions accept
    localparam int MAX_PTR_W  = 16;

    // --------------------
    // Flag bundles
    // --------------------

    // Write side status
    typedef struct packed {
        logic full;
        logic afull;
    } wr_flags_t;

    // Read side status, rdata_valid marks the word on rdata
    typedef struct packed {
        logic empty;
        logic aempty;
        logic hempty;
        logic rdata_valid;
    } rd_flags_t;

    // --------------------
    // Gray code helpers
    // --------------------

    // Adjacent codes differ in one bit
    function automatic logic [MAX_PTR_W-1:0] bin_to_gray(input logic [MAX_PTR_W-1:0] bin);
        return bin ^ (bin >> 1);
    endfunction

    // MSB passes through, each lower bit folds in the one above
    function automatic logic [MAX_PTR_W-1:0] gray_to_bin(input logic [MAX_PTR_W-1:0] gray);
        logic [MAX_PTR_W-1:0] bin;
        bin[MAX_PTR_W-1] = gray[MAX_PTR_W-1];
        for (int i = MAX_PTR_W - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

// File: rtl/ptr_sync.sv
/* Two-flop synchronizer for a Gray pointer, result in binary */

`timescale 1ns/1ns

module ptr_sync #(
    parameter int PTR_W = fifo_pkg::DEF_ADDR_W + 1
) (
    input  logic             dclk_i,
    input  logic             rstn_i,
    input  logic [PTR_W-1:0] gray_ptr_i,
    output logic [PTR_W-1:0] bin_ptr_o
);

    // First stage may go metastable, second stage is the safe copy
    logic [PTR_W-1:0] meta_q;
    logic [PTR_W-1:0] sync_q;

    // Padded to the width the package functions take
    logic [fifo_pkg::MAX_PTR_W-1:0] gray_ext;
    logic [fifo_pkg::MAX_PTR_W-1:0] bin_ext;

    always_ff @(posedge dclk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            meta_q <= '0;
            sync_q <= '0;
        end else begin
            meta_q <= gray_ptr_i;
            sync_q <= meta_q;
        end
    end

    // Convert back so the counting side works in binary
    always_comb begin
        gray_ext            = '0;
        gray_ext[PTR_W-1:0] = sync_q;
        bin_ext             = fifo_pkg::gray_to_bin(gray_ext);
    end

    assign bin_ptr_o = bin_ext[PTR_W-1:0];

endmodule

// File: rtl/rd_ptr_ctrl.sv
/* Read pointer counter with empty and threshold flags,
   read side fill count and the read data valid strobe */

`timescale 1ns/1ns

module rd_ptr_ctrl #(
    parameter int ADDR_W       = fifo_pkg::DEF_ADDR_W,
    parameter int AEMPTY_LEVEL = 10
) (
    input  logic                rclk_i,
    input  logic                rstn_i,
    input  logic                ren_i,
    input  logic [ADDR_W:0]     wr_bin_sync_i,
    output logic [ADDR_W:0]     rd_gray_o,
    output logic [ADDR_W-1:0]   mem_raddr_o,
    output fifo_pkg::rd_flags_t rd_flags_o,
    output logic [ADDR_W:0]     rcount_o
);

    // Threshold levels at pointer width
    localparam logic [ADDR_W:0] AEMPTY_THR = (ADDR_W + 1)'(AEMPTY_LEVEL);
    // Half empty is fixed at half the depth
    localparam logic [ADDR_W:0] HEMPTY_THR = (ADDR_W + 1)'(2 ** (ADDR_W - 1));

    logic [ADDR_W:0]     rd_bin_q;
    logic [ADDR_W:0]     rd_gray_q;
    logic [ADDR_W:0]     rd_bin_next;
    logic [ADDR_W:0]     rd_gray_next;
    logic [ADDR_W:0]     wr_gray_sync;
    logic [ADDR_W:0]     fill;
    logic [ADDR_W:0]     rcount_q;
    logic                rd_accept;
    fifo_pkg::rd_flags_t rd_flags_q;

    // Scratch words for the package conversions
    logic [fifo_pkg::MAX_PTR_W-1:0] next_bin_ext;
    logic [fifo_pkg::MAX_PTR_W-1:0] next_gray_ext;
    logic [fifo_pkg::MAX_PTR_W-1:0] sync_bin_ext;
    logic [fifo_pkg::MAX_PTR_W-1:0] sync_gray_ext;

    // --------------------
    // Next pointer
    // --------------------

    // Reads against an empty FIFO are ignored
    assign rd_accept   = ren_i & ~rd_flags_q.empty;
    assign rd_bin_next = rd_bin_q + {{ADDR_W{1'b0}}, rd_accept};

    always_comb begin
        next_bin_ext           = '0;
        next_bin_ext[ADDR_W:0] = rd_bin_next;
        next_gray_ext          = fifo_pkg::bin_to_gray(next_bin_ext);
        rd_gray_next           = next_gray_ext[ADDR_W:0];
        sync_bin_ext           = '0;
        sync_bin_ext[ADDR_W:0] = wr_bin_sync_i;
        sync_gray_ext          = fifo_pkg::bin_to_gray(sync_bin_ext);
        wr_gray_sync           = sync_gray_ext[ADDR_W:0];
    end

    // Words held as seen from the read clock
    assign fill = wr_bin_sync_i - rd_bin_q;

    // --------------------
    // Registers
    // --------------------

    always_ff @(posedge rclk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rd_bin_q   <= '0;
            rd_gray_q  <= '0;
            rd_flags_q <= '{empty: 1'b1, aempty: 1'b1, hempty: 1'b1, rdata_valid: 1'b0};
            rcount_q   <= '0;
        end else begin
            rd_bin_q               <= rd_bin_next;
            rd_gray_q              <= rd_gray_next;
            // Empty once the reader catches up with the synced writer
            rd_flags_q.empty       <= (rd_gray_next == wr_gray_sync);
            rd_flags_q.aempty      <= (fill <= AEMPTY_THR);
            rd_flags_q.hempty      <= (fill <= HEMPTY_THR);
            // Word of this read shows on rdata one cycle later
            rd_flags_q.rdata_valid <= rd_accept;
            rcount_q               <= fill;
        end
    end

    assign rd_gray_o = rd_gray_q;
    // RAM registers this address on the same edge the pointer moves
    assign mem_raddr_o = rd_bin_q[ADDR_W-1:0];
    assign rd_flags_o  = rd_flags_q;
    assign rcount_o    = rcount_q;

    // Valid only follows an accepted read of a word that was really held
    a_valid_after_accept : assert property (@(posedge rclk_i) disable iff (!rstn_i)
        rd_flags_q.rdata_valid |-> $past(ren_i && !rd_flags_q.empty && fill != '0));

endmodule

// File: rtl/wr_ptr_ctrl.sv
/* Write pointer counter with full and almost-full flags
   and the write side fill count */

`timescale 1ns/1ns

module wr_ptr_ctrl #(
    parameter int ADDR_W      = fifo_pkg::DEF_ADDR_W,
    parameter int AFULL_LEVEL = (2 ** fifo_pkg::DEF_ADDR_W) - 1
) (
    input  logic                wclk_i,
    input  logic                rstn_i,
    input  logic                wen_i,
    input  logic [ADDR_W:0]     rd_bin_sync_i,
    output logic [ADDR_W:0]     wr_gray_o,
    output logic                mem_we_o,
    output logic [ADDR_W-1:0]   mem_waddr_o,
    output fifo_pkg::wr_flags_t wr_flags_o,
    output logic [ADDR_W:0]     wcount_o
);

    // Thresholds sized to the pointer width
    localparam logic [ADDR_W:0] DEPTH     = (ADDR_W + 1)'(2 ** ADDR_W);
    localparam logic [ADDR_W:0] AFULL_THR = (ADDR_W + 1)'(AFULL_LEVEL);

    // Pointers carry one extra wrap bit
    logic [ADDR_W:0]     wr_bin_q;
    logic [ADDR_W:0]     wr_gray_q;
    logic [ADDR_W:0]     wr_bin_next;
    logic [ADDR_W:0]     wr_gray_next;
    logic [ADDR_W:0]     rd_gray_sync;
    logic [ADDR_W:0]     full_match;
    logic [ADDR_W:0]     fill;
    logic [ADDR_W:0]     wcount_q;
    fifo_pkg::wr_flags_t wr_flags_q;

    // Scratch words for the package conversions
    logic [fifo_pkg::MAX_PTR_W-1:0] next_bin_ext;
    logic [fifo_pkg::MAX_PTR_W-1:0] next_gray_ext;
    logic [fifo_pkg::MAX_PTR_W-1:0] sync_bin_ext;
    logic [fifo_pkg::MAX_PTR_W-1:0] sync_gray_ext;

    // --------------------
    // Next pointer
    // --------------------

    // A request against a full FIFO is dropped here
    assign mem_we_o    = wen_i & ~wr_flags_q.full;
    assign wr_bin_next = wr_bin_q + {{ADDR_W{1'b0}}, mem_we_o};

    always_comb begin
        next_bin_ext             = '0;
        next_bin_ext[ADDR_W:0]   = wr_bin_next;
        next_gray_ext            = fifo_pkg::bin_to_gray(next_bin_ext);
        wr_gray_next             = next_gray_ext[ADDR_W:0];
        sync_bin_ext             = '0;
        sync_bin_ext[ADDR_W:0]   = rd_bin_sync_i;
        sync_gray_ext            = fifo_pkg::bin_to_gray(sync_bin_ext);
        rd_gray_sync             = sync_gray_ext[ADDR_W:0];
    end

    // One lap ahead of the reader shows as the two Gray MSBs flipped
    assign full_match = {~rd_gray_sync[ADDR_W:ADDR_W-1], rd_gray_sync[ADDR_W-2:0]};

    // Words held as seen from the write clock
    assign fill = wr_bin_q - rd_bin_sync_i;

    // --------------------
    // Registers
    // --------------------

    always_ff @(posedge wclk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_bin_q   <= '0;
            wr_gray_q  <= '0;
            wr_flags_q <= '{full: 1'b0, afull: 1'b0};
            wcount_q   <= '0;
        end else begin
            wr_bin_q         <= wr_bin_next;
            wr_gray_q        <= wr_gray_next;
            // Rises on the edge that takes the last free slot
            wr_flags_q.full  <= (wr_gray_next == full_match);
            // Level flag and count lag one cycle behind the pointers
            wr_flags_q.afull <= (fill >= AFULL_THR);
            wcount_q         <= fill;
        end
    end

    assign wr_gray_o   = wr_gray_q;
    assign mem_waddr_o = wr_bin_q[ADDR_W-1:0];
    assign wr_flags_o  = wr_flags_q;
    assign wcount_o    = wcount_q;

    // The synchronized read pointer may lag but never lets the writer lap it
    a_fill_in_range : assert property (@(posedge wclk_i) disable iff (!rstn_i)
        fill <= DEPTH);

    // A write only lands in a slot the reader has already freed
    a_no_write_when_full : assert property (@(posedge wclk_i) disable iff (!rstn_i)
        mem_we_o |-> fill < DEPTH);

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the FIFO testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f build.f --top-module tb_async_fifo -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_async_fifo)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: verification/fifo_model.svh
/* Reference queue model, expected flags for a settled fill level
   and the xorshift generator, included inside the testbench */

`ifndef FIFO_MODEL_SVH
`define FIFO_MODEL_SVH

// Words taken by the writer and not yet seen on the read side
// Width follows DATA_W of the including module
logic [DATA_W-1:0] model_q[$];

// Flags expected once both pointers have crossed over
typedef struct packed {
    logic full;
    logic afull;
    logic empty;
    logic aempty;
    logic hempty;
} level_flags_t;

// --------------------
// Reference rules
// --------------------

function automatic level_flags_t expected_flags(input int fill, input int depth,
                                                input int afull_lvl, input int aempty_lvl);
    level_flags_t f;
    f.full   = (fill == depth);
    f.afull  = (fill >= afull_lvl);
    f.empty  = (fill == 0);
    f.aempty = (fill <= aempty_lvl);
    // Half empty is pinned to half the depth
    f.hempty = (fill <= depth / 2);
    return f;
endfunction

// One xorshift32 step, a nonzero state never returns zero
function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

`endif

// File: verification/tb_async_fifo.sv
/* Testbench for the dual-clock FIFO, random bursts, fill and drain
   runs and flag checks at settled fill levels */

`timescale 1ns/1ns

module tb_async_fifo;

    localparam int ADDR_W       = 5;
    localparam int DATA_W       = 32;
    localparam int DEPTH        = 2 ** ADDR_W;
    localparam int AFULL_LEVEL  = 31;
    localparam int AEMPTY_LEVEL = 10;
    localparam int DRIVE_DELAY  = 2;
    localparam int WAIT_LIMIT   = 400;

    logic                rstn_i;
    logic                wclk_i;
    logic                rclk_i;
    logic                wen_i;
    logic [DATA_W-1:0]   wdata_i;
    logic                ren_i;
    logic [DATA_W-1:0]   rdata_o;
    fifo_pkg::wr_flags_t wr_flags_o;
    fifo_pkg::rd_flags_t rd_flags_o;
    logic [ADDR_W:0]     wcount_o;
    logic [ADDR_W:0]     rcount_o;

    // Counters kept by the monitors
    int          wr_accepts  = 0;
    int          rd_accepts  = 0;
    int          rd_words    = 0;
    int          fail_count  = 0;
    logic        rd_accept_q = 1'b0;
    // Separate streams per process, all from one seed
    logic [31:0] wr_rng      = 32'h336;
    logic [31:0] rd_rng      = 32'h336 ^ 32'h5a5a5a5a;
    logic [31:0] lvl_rng     = 32'h336 ^ 32'hc3c3c3c3;

    `include "fifo_model.svh"

    async_fifo #(
        .ADDR_W       (ADDR_W),
        .DATA_W       (DATA_W),
        .AFULL_LEVEL  (AFULL_LEVEL),
        .AEMPTY_LEVEL (AEMPTY_LEVEL)
    ) DUT (
        .rstn_i     (rstn_i),
        .wclk_i     (wclk_i),
        .rclk_i     (rclk_i),
        .wen_i      (wen_i),
        .wdata_i    (wdata_i),
        .ren_i      (ren_i),
        .rdata_o    (rdata_o),
        .wr_flags_o (wr_flags_o),
        .rd_flags_o (rd_flags_o),
        .wcount_o   (wcount_o),
        .rcount_o   (rcount_o)
    );

    // Write clock 28 ns, read clock 40 ns
    initial begin
        wclk_i = 1'b0;
        forever #14 wclk_i = ~wclk_i;
    end

    initial begin
        rclk_i = 1'b0;
        forever #20 rclk_i = ~rclk_i;
    end

    // --------------------
    // Failure handling
    // --------------------

    task automatic stop_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped after the first failure");
    endtask

    task automatic value_error(input string msg);
        fail_count++;
        $display("Error at %0t ns: %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic timeout_error(input string what);
        fail_count++;
        $display("Timed out at %0t ns while %s", $time, what);
        stop_with_failure();
    endtask

    // --------------------
    // Monitors
    // --------------------

    // Mid cycle, so wen and full are settled for the coming edge
    always @(negedge wclk_i) begin
        if (rstn_i && wen_i && !wr_flags_o.full) begin
            model_q.push_back(wdata_i);
            wr_accepts++;
        end
    end

    // Read side compare against the head of the model
    always @(negedge rclk_i) begin
        logic [DATA_W-1:0] expected;
        if (rstn_i) begin
            assert (rd_flags_o.rdata_valid == rd_accept_q) else
                value_error($sformatf("rdata_valid %0b after a cycle with accepted read %0b",
                                      rd_flags_o.rdata_valid, rd_accept_q));
            if (rd_flags_o.rdata_valid) begin
                assert (model_q.size() != 0) else
                    value_error("valid read data while the model holds no word");
                expected = model_q.pop_front();
                assert (rdata_o == expected) else
                    value_error($sformatf("rdata_o %h, expected %h", rdata_o, expected));
                rd_words++;
            end
            // Taken on the next rclk edge
            rd_accept_q = ren_i && !rd_flags_o.empty;
            if (rd_accept_q) begin
                rd_accepts++;
            end
        end
    end

    // Words held by the DUT, counting a read whose strobe is still due
    function automatic int fifo_level();
        return model_q.size() - (rd_accepts - rd_words);
    endfunction

    // --------------------
    // Stimulus
    // --------------------

    task automatic write_burst(input int cycles, input logic [3:0] density);
        repeat (cycles) begin
            @(posedge wclk_i);
            #DRIVE_DELAY;
            wr_rng  = xorshift32(wr_rng);
            wen_i   = (wr_rng[3:0] < density);
            wr_rng  = xorshift32(wr_rng);
            wdata_i = wr_rng;
        end
        @(posedge wclk_i);
        #DRIVE_DELAY;
        wen_i = 1'b0;
    endtask

    task automatic read_burst(input int cycles, input logic [3:0] density);
        repeat (cycles) begin
            @(posedge rclk_i);
            #DRIVE_DELAY;
            rd_rng = xorshift32(rd_rng);
            ren_i  = (rd_rng[3:0] < density);
        end
        @(posedge rclk_i);
        #DRIVE_DELAY;
        ren_i = 1'b0;
    endtask

    // Idle both sides, then counts and flags must match the model
    task automatic check_settled();
        level_flags_t    exp;
        logic [ADDR_W:0] exp_count;
        int              size;
        fork
            repeat (8) @(posedge wclk_i);
            repeat (8) @(posedge rclk_i);
        join
        #DRIVE_DELAY;
        size      = model_q.size();
        exp       = expected_flags(size, DEPTH, AFULL_LEVEL, AEMPTY_LEVEL);
        exp_count = (ADDR_W + 1)'(size);
        assert (wcount_o == exp_count && rcount_o == exp_count) else
            value_error($sformatf("counts %0d and %0d, expected %0d", wcount_o, rcount_o, size));
        assert (wr_flags_o.full == exp.full && wr_flags_o.afull == exp.afull) else
            value_error($sformatf("write flags %b at fill %0d", wr_flags_o, size));
        assert (rd_flags_o.empty == exp.empty && rd_flags_o.aempty == exp.aempty
                && rd_flags_o.hempty == exp.hempty && !rd_flags_o.rdata_valid) else
            value_error($sformatf("read flags %b at fill %0d", rd_flags_o, size));
    endtask

    // Step one side at a time until the level hits the target
    task automatic move_to_level(input int target);
        int n;
        n = 0;
        while (fifo_level() < target) begin
            if (n == WAIT_LIMIT) timeout_error($sformatf("filling to %0d words", target));
            @(posedge wclk_i);
            #DRIVE_DELAY;
            wr_rng  = xorshift32(wr_rng);
            wdata_i = wr_rng;
            wen_i   = (fifo_level() < target);
            n++;
        end
        while (fifo_level() > target) begin
            if (n == WAIT_LIMIT) timeout_error($sformatf("reading down to %0d words", target));
            @(posedge rclk_i);
            #DRIVE_DELAY;
            ren_i = (fifo_level() > target);
            n++;
        end
    endtask

    task automatic fill_to_full();
        int n;
        int start;
        n     = 0;
        start = wr_accepts;
        while (!wr_flags_o.full) begin
            if (n == WAIT_LIMIT) timeout_error("waiting for full");
            @(posedge wclk_i);
            #DRIVE_DELAY;
            wr_rng  = xorshift32(wr_rng);
            wdata_i = wr_rng;
            wen_i   = 1'b1;
            n++;
        end
        // Pulses against a full FIFO must be dropped
        repeat (6) begin
            @(posedge wclk_i);
            #DRIVE_DELAY;
            wr_rng  = xorshift32(wr_rng);
            wdata_i = wr_rng;
            wen_i   = ~wen_i;
        end
        wen_i = 1'b0;
        assert (wr_accepts - start == DEPTH && model_q.size() == DEPTH) else
            value_error($sformatf("%0d writes accepted before full", wr_accepts - start));
    endtask

    task automatic drain_to_empty();
        int n;
        n = 0;
        @(posedge rclk_i);
        #DRIVE_DELAY;
        ren_i = 1'b1;
        while (!rd_flags_o.empty) begin
            if (n == WAIT_LIMIT) timeout_error("waiting for empty");
            @(posedge rclk_i);
            #DRIVE_DELAY;
            n++;
        end
        // A few reads against the empty FIFO
        repeat (4) begin
            @(posedge rclk_i);
            #DRIVE_DELAY;
        end
        ren_i = 1'b0;
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial begin
        int start;
        int target;
        rstn_i  = 1'b0;
        wen_i   = 1'b0;
        ren_i   = 1'b0;
        wdata_i = '0;
        repeat (4) @(posedge rclk_i);
        #DRIVE_DELAY;
        rstn_i = 1'b1;

        assert (!wr_flags_o.full && !wr_flags_o.afull && rd_flags_o.empty && rd_flags_o.aempty
                && rd_flags_o.hempty && !rd_flags_o.rdata_valid) else
            value_error($sformatf("flags after reset %b %b", wr_flags_o, rd_flags_o));
        assert (wcount_o == '0 && rcount_o == '0) else
            value_error("counts not zero after reset");
        check_settled();

        // Writer heavy, then reader heavy
        fork
            write_burst(300, 4'd12);
            read_burst(200, 4'd6);
        join
        fork
            write_burst(300, 4'd5);
            read_burst(220, 4'd12);
        join
        check_settled();
        drain_to_empty();
        check_settled();

        fill_to_full();
        check_settled();
        start = rd_words;
        drain_to_empty();
        check_settled();
        assert (rd_words - start == DEPTH) else
            value_error($sformatf("%0d words drained, expected %0d", rd_words - start, DEPTH));

        repeat (6) begin
            lvl_rng = xorshift32(lvl_rng);
            target  = int'(lvl_rng % 32'(DEPTH + 1));
            move_to_level(target);
            check_settled();
        end

        if (fail_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule
